//--- hdl/load_port.sv
`timescale 1ns/1ps

module load_port (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           load_valid,
  input  logic [lsq_pkg::ADDR_WIDTH-1:0] load_addr,
  output logic                           load_ready,
  input  logic                           hit,
  input  logic [lsq_pkg::DATA_WIDTH-1:0] hit_data,
  output logic                           arvalid,
  output logic [lsq_pkg::ADDR_WIDTH-1:0] araddr,
  input  logic                           arready,
  input  logic                           rvalid,
  input  logic [lsq_pkg::DATA_WIDTH-1:0] rdata,
  input  lsq_pkg::axi_resp_t             rresp,
  output logic                           rready,
  output logic                           load_resp_valid,
  output logic [lsq_pkg::DATA_WIDTH-1:0] load_resp_data,
  output logic                           load_resp_forwarded,
  input  logic                           load_resp_ready
);

  import lsq_pkg::*;

  typedef enum logic [1:0] {
    load_idle,
    load_read_addr,
    load_read_data,
    load_respond
  } load_state_t;

  load_state_t           state;
  logic                  accept;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic [DATA_WIDTH-1:0] data_q;
  logic                  forwarded_q;

  assign load_ready          = (state == load_idle);
  assign accept              = load_valid && load_ready;
  assign arvalid             = (state == load_read_addr);
  assign araddr              = {addr_q[ADDR_WIDTH-1:2], 2'b00};
  assign rready              = (state == load_read_data);
  assign load_resp_valid     = (state == load_respond);
  assign load_resp_data      = data_q;
  assign load_resp_forwarded = forwarded_q;

  // Forward result is frozen at acceptance
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= load_idle;
    end else begin
      case (state)
        load_idle: begin
          if (accept) begin
            state <= hit ? load_respond : load_read_addr;
          end
        end
        load_read_addr: begin
          if (arready) begin
            state <= load_read_data;
          end
        end
        load_read_data: begin
          if (rvalid) begin
            state <= load_respond;
          end
        end
        default: begin
          if (load_resp_ready) begin
            state <= load_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      addr_q      <= load_addr;
      data_q      <= hit_data;
      forwarded_q <= hit;
    end else if (rready && rvalid) begin
      data_q <= rdata;
    end
  end

endmodule

//--- hdl/lsq_pkg.sv
package lsq_pkg;

  // Queue geometry
  localparam int SQ_DEPTH     = 8;
  localparam int SQ_IDX_WIDTH = 3;

  // Memory access widths
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;

  // One word per access, byte offset is dropped
  localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - 2;
  localparam int STRB_WIDTH      = DATA_WIDTH / 8;

  // Slot index plus a wrap bit on top
  typedef logic [SQ_IDX_WIDTH:0] sq_ptr_t;

  // Occupancy and pending counts, 0 to SQ_DEPTH
  typedef logic [SQ_IDX_WIDTH:0] sq_count_t;

  typedef struct packed {
    logic                       executed;
    logic [WORD_ADDR_WIDTH-1:0] word_addr;
    logic [DATA_WIDTH-1:0]      data;
  } sq_entry_t;

  typedef logic [1:0] axi_resp_t;

endpackage

//--- hdl/store_alloc.sv
`timescale 1ns/1ps

module store_alloc (
  input  logic             clock,
  input  logic             reset,
  input  logic             dispatch_valid,
  input  logic             dispatch_store,
  input  logic             free_fire,
  output logic             dispatch_ready,
  output lsq_pkg::sq_ptr_t dispatch_sq_idx,
  output logic             alloc_fire,
  output lsq_pkg::sq_ptr_t tail
);

  import lsq_pkg::*;

  sq_count_t count;
  logic      full;

  assign full = (count == sq_count_t'(SQ_DEPTH));

  // Loads never stall, they only read the tail as their boundary
  assign dispatch_ready  = !(dispatch_store && full);
  assign dispatch_sq_idx = tail;
  assign alloc_fire      = dispatch_valid && dispatch_store && !full;

  always_ff @(posedge clock) begin
    if (reset) begin
      tail <= '0;
    end else if (alloc_fire) begin
      tail <= tail + 1'b1;
    end
  end

  // Allocate and free may land in the same cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
    end else begin
      case ({alloc_fire, free_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- hdl/store_buffer.sv
`timescale 1ns/1ps

module store_buffer (
  input  logic                                       clock,
  input  logic                                       reset,
  input  logic                                       alloc_fire,
  input  lsq_pkg::sq_ptr_t                           tail,
  input  logic                                       exec_valid,
  input  logic [lsq_pkg::SQ_IDX_WIDTH-1:0]           exec_idx,
  input  logic [lsq_pkg::ADDR_WIDTH-1:0]             exec_addr,
  input  logic [lsq_pkg::DATA_WIDTH-1:0]             exec_data,
  input  lsq_pkg::sq_ptr_t                           head,
  output lsq_pkg::sq_entry_t [lsq_pkg::SQ_DEPTH-1:0] entries,
  output lsq_pkg::sq_entry_t                         head_entry
);

  import lsq_pkg::*;

  logic [SQ_DEPTH-1:0]        executed;
  logic [WORD_ADDR_WIDTH-1:0] word_addr [SQ_DEPTH];
  logic [DATA_WIDTH-1:0]      data      [SQ_DEPTH];
  logic [SQ_IDX_WIDTH-1:0]    tail_slot;
  logic [SQ_IDX_WIDTH-1:0]    head_slot;

  assign tail_slot = tail[SQ_IDX_WIDTH-1:0];
  assign head_slot = head[SQ_IDX_WIDTH-1:0];

  // A new store starts unexecuted; execution marks it ready to forward
  always_ff @(posedge clock) begin
    if (reset) begin
      executed <= '0;
    end else begin
      if (alloc_fire) begin
        executed[tail_slot] <= 1'b0;
      end
      if (exec_valid) begin
        executed[exec_idx] <= 1'b1;
      end
    end
  end

  // Address and data arrive together from the store unit
  always_ff @(posedge clock) begin
    if (exec_valid) begin
      word_addr[exec_idx] <= exec_addr[ADDR_WIDTH-1:2];
      data[exec_idx]      <= exec_data;
    end
  end

  for (genvar g = 0; g < SQ_DEPTH; g++) begin : gen_entry
    assign entries[g] = '{
      executed:  executed[g],
      word_addr: word_addr[g],
      data:      data[g]
    };
  end

  // Oldest store, next to drain
  assign head_entry = entries[head_slot];

endmodule

//--- hdl/store_drain.sv
`timescale 1ns/1ps

module store_drain (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             commit_valid,
  input  lsq_pkg::sq_entry_t               head_entry,
  output logic                             awvalid,
  output logic [lsq_pkg::ADDR_WIDTH-1:0]   awaddr,
  input  logic                             awready,
  output logic                             wvalid,
  output logic [lsq_pkg::DATA_WIDTH-1:0]   wdata,
  output logic [lsq_pkg::STRB_WIDTH-1:0]   wstrb,
  input  logic                             wready,
  input  logic                             bvalid,
  input  lsq_pkg::axi_resp_t               bresp,
  output logic                             bready,
  output lsq_pkg::sq_ptr_t                 head,
  output logic                             free_fire
);

  import lsq_pkg::*;

  typedef enum logic [1:0] {
    drain_idle,
    drain_addr_data,
    drain_wait_resp
  } drain_state_t;

  drain_state_t state;
  sq_count_t    pending;
  logic         aw_done;
  logic         w_done;
  logic         aw_fire;
  logic         w_fire;
  logic         both_done;

  assign awvalid   = (state == drain_addr_data) && !aw_done;
  assign wvalid    = (state == drain_addr_data) && !w_done;
  assign awaddr    = {head_entry.word_addr, 2'b00};
  assign wdata     = head_entry.data;
  assign wstrb     = '1;
  assign bready    = (state == drain_wait_resp);
  assign aw_fire   = awvalid && awready;
  assign w_fire    = wvalid && wready;
  assign both_done = (aw_done || aw_fire) && (w_done || w_fire);
  assign free_fire = bready && bvalid;

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= drain_idle;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      case (state)
        drain_idle: begin
          if (pending != '0) begin
            state <= drain_addr_data;
          end
        end
        drain_addr_data: begin
          if (both_done) begin
            state   <= drain_wait_resp;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
          end else begin
            aw_done <= aw_done || aw_fire;
            w_done  <= w_done || w_fire;
          end
        end
        default: begin
          if (bvalid) begin
            state <= drain_idle;
          end
        end
      endcase
    end
  end

  // Commits seen but not yet written, store retires on the B handshake
  always_ff @(posedge clock) begin
    if (reset) begin
      pending <= '0;
      head    <= '0;
    end else begin
      if (commit_valid && !free_fire) begin
        pending <= pending + 1'b1;
      end else if (free_fire && !commit_valid) begin
        pending <= pending - 1'b1;
      end
      if (free_fire) begin
        head <= head + 1'b1;
      end
    end
  end

endmodule

//--- hdl/store_forward.sv
`timescale 1ns/1ps

module store_forward (
  input  lsq_pkg::sq_entry_t [lsq_pkg::SQ_DEPTH-1:0] entries,
  input  lsq_pkg::sq_ptr_t                           head,
  input  logic [lsq_pkg::ADDR_WIDTH-1:0]             load_addr,
  input  lsq_pkg::sq_ptr_t                           load_sq_idx,
  output logic                                       hit,
  output logic [lsq_pkg::DATA_WIDTH-1:0]             hit_data
);

  import lsq_pkg::*;

  sq_ptr_t                    span;
  logic                       span_ok;
  logic [WORD_ADDR_WIDTH-1:0] load_word;

  // Number of live stores older than the load
  assign span      = load_sq_idx - head;
  assign span_ok   = (span <= sq_ptr_t'(SQ_DEPTH));
  assign load_word = load_addr[ADDR_WIDTH-1:2];

  // Walk back from the boundary; first match is the youngest older store
  always_comb begin
    sq_ptr_t   ptr;
    sq_entry_t slot;
    hit      = 1'b0;
    hit_data = '0;
    for (int j = 1; j <= SQ_DEPTH; j++) begin
      ptr  = load_sq_idx - sq_ptr_t'(j);
      slot = entries[ptr[SQ_IDX_WIDTH-1:0]];
      if (!hit && span_ok && (sq_ptr_t'(j) <= span) && slot.executed &&
          (slot.word_addr == load_word)) begin
        hit      = 1'b1;
        hit_data = slot.data;
      end
    end
  end

endmodule

//--- hdl/store_queue_top.sv
`timescale 1ns/1ps

module store_queue_top (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           dispatch_valid,
  input  logic                           dispatch_store,
  output logic                           dispatch_ready,
  output lsq_pkg::sq_ptr_t               dispatch_sq_idx,
  input  logic                           exec_valid,
  input  logic [lsq_pkg::SQ_IDX_WIDTH-1:0] exec_idx,
  input  logic [lsq_pkg::ADDR_WIDTH-1:0] exec_addr,
  input  logic [lsq_pkg::DATA_WIDTH-1:0] exec_data,
  input  logic                           commit_valid,
  input  logic                           load_valid,
  input  logic [lsq_pkg::ADDR_WIDTH-1:0] load_addr,
  input  lsq_pkg::sq_ptr_t               load_sq_idx,
  output logic                           load_ready,
  output logic                           load_resp_valid,
  output logic [lsq_pkg::DATA_WIDTH-1:0] load_resp_data,
  output logic                           load_resp_forwarded,
  input  logic                           load_resp_ready,
  output logic                           awvalid,
  input  logic                           awready,
  output logic [lsq_pkg::ADDR_WIDTH-1:0] awaddr,
  output logic                           wvalid,
  input  logic                           wready,
  output logic [lsq_pkg::DATA_WIDTH-1:0] wdata,
  output logic [lsq_pkg::STRB_WIDTH-1:0] wstrb,
  input  logic                           bvalid,
  output logic                           bready,
  input  lsq_pkg::axi_resp_t             bresp,
  output logic                           arvalid,
  input  logic                           arready,
  output logic [lsq_pkg::ADDR_WIDTH-1:0] araddr,
  input  logic                           rvalid,
  output logic                           rready,
  input  logic [lsq_pkg::DATA_WIDTH-1:0] rdata,
  input  lsq_pkg::axi_resp_t             rresp
);

  import lsq_pkg::*;

  logic                          alloc_fire;
  logic                          free_fire;
  sq_ptr_t                       tail;
  sq_ptr_t                       head;
  sq_entry_t [SQ_DEPTH-1:0]      entries;
  sq_entry_t                     head_entry;
  logic                          hit;
  logic [DATA_WIDTH-1:0]         hit_data;

  store_alloc store_alloc_inst (
    .clock           (clock),
    .reset           (reset),
    .dispatch_valid  (dispatch_valid),
    .dispatch_store  (dispatch_store),
    .free_fire       (free_fire),
    .dispatch_ready  (dispatch_ready),
    .dispatch_sq_idx (dispatch_sq_idx),
    .alloc_fire      (alloc_fire),
    .tail            (tail)
  );

  store_buffer store_buffer_inst (
    .clock      (clock),
    .reset      (reset),
    .alloc_fire (alloc_fire),
    .tail       (tail),
    .exec_valid (exec_valid),
    .exec_idx   (exec_idx),
    .exec_addr  (exec_addr),
    .exec_data  (exec_data),
    .head       (head),
    .entries    (entries),
    .head_entry (head_entry)
  );

  store_forward store_forward_inst (
    .entries     (entries),
    .head        (head),
    .load_addr   (load_addr),
    .load_sq_idx (load_sq_idx),
    .hit         (hit),
    .hit_data    (hit_data)
  );

  store_drain store_drain_inst (
    .clock        (clock),
    .reset        (reset),
    .commit_valid (commit_valid),
    .head_entry   (head_entry),
    .awvalid      (awvalid),
    .awaddr       (awaddr),
    .awready      (awready),
    .wvalid       (wvalid),
    .wdata        (wdata),
    .wstrb        (wstrb),
    .wready       (wready),
    .bvalid       (bvalid),
    .bresp        (bresp),
    .bready       (bready),
    .head         (head),
    .free_fire    (free_fire)
  );

  load_port load_port_inst (
    .clock               (clock),
    .reset               (reset),
    .load_valid          (load_valid),
    .load_addr           (load_addr),
    .load_ready          (load_ready),
    .hit                 (hit),
    .hit_data            (hit_data),
    .arvalid             (arvalid),
    .araddr              (araddr),
    .arready             (arready),
    .rvalid              (rvalid),
    .rdata               (rdata),
    .rresp               (rresp),
    .rready              (rready),
    .load_resp_valid     (load_resp_valid),
    .load_resp_data      (load_resp_data),
    .load_resp_forwarded (load_resp_forwarded),
    .load_resp_ready     (load_resp_ready)
  );

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module store_queue_tb -f sim.f

output="$(./obj_dir/Vstore_queue_tb)"
echo "$output"

grep -qxF '>>> PASS' <<< "$output"

//--- sim.f
hdl/lsq_pkg.sv
hdl/store_alloc.sv
hdl/store_buffer.sv
hdl/store_forward.sv
hdl/store_drain.sv
hdl/load_port.sv
hdl/store_queue_top.sv
tb/store_queue_tb.sv

//--- tb/store_queue_tb.sv
`timescale 1ns/1ps

module store_queue_tb;

  import lsq_pkg::*;

  localparam int TIMEOUT_CYCLES = 50;

  logic                    clock = 1'b0;
  logic                    reset;
  logic                    dispatch_valid;
  logic                    dispatch_store;
  logic                    dispatch_ready;
  sq_ptr_t                 dispatch_sq_idx;
  logic                    exec_valid;
  logic [SQ_IDX_WIDTH-1:0] exec_idx;
  logic [ADDR_WIDTH-1:0]   exec_addr;
  logic [DATA_WIDTH-1:0]   exec_data;
  logic                    commit_valid;
  logic                    load_valid;
  logic [ADDR_WIDTH-1:0]   load_addr;
  sq_ptr_t                 load_sq_idx;
  logic                    load_ready;
  logic                    load_resp_valid;
  logic [DATA_WIDTH-1:0]   load_resp_data;
  logic                    load_resp_forwarded;
  logic                    load_resp_ready;
  logic                    awvalid;
  logic                    awready = 1'b0;
  logic [ADDR_WIDTH-1:0]   awaddr;
  logic                    wvalid;
  logic                    wready = 1'b0;
  logic [DATA_WIDTH-1:0]   wdata;
  logic [STRB_WIDTH-1:0]   wstrb;
  logic                    bvalid = 1'b0;
  logic                    bready;
  axi_resp_t               bresp = 2'b00;
  logic                    arvalid;
  logic                    arready = 1'b0;
  logic [ADDR_WIDTH-1:0]   araddr;
  logic                    rvalid = 1'b0;
  logic                    rready;
  logic [DATA_WIDTH-1:0]   rdata = '0;
  axi_resp_t               rresp = 2'b00;

  // Memory model state
  logic [DATA_WIDTH-1:0] mem [logic [WORD_ADDR_WIDTH-1:0]];
  logic [ADDR_WIDTH-1:0] write_log_addr [$];
  logic [DATA_WIDTH-1:0] write_log_data [$];
  logic [ADDR_WIDTH-1:0] wr_addr_q;
  logic [DATA_WIDTH-1:0] wr_data_q;
  logic [ADDR_WIDTH-1:0] rd_addr_q;
  logic                  aw_held = 1'b0;
  logic                  w_held = 1'b0;
  logic                  ar_held = 1'b0;
  logic                  b_fire = 1'b0;
  logic                  r_fire = 1'b0;
  int                    aw_wait;
  int                    w_wait;
  int                    b_wait;
  int                    ar_wait;
  int                    r_wait;

  logic [ADDR_WIDTH-1:0] store_addr [SQ_DEPTH];
  logic [DATA_WIDTH-1:0] store_data [SQ_DEPTH];
  sq_ptr_t               load_bound;
  int                    errors;
  int                    tests;

  store_queue_top store_queue_top_inst (.*);

  always #10 clock = ~clock;

  function automatic logic [DATA_WIDTH-1:0] mem_read(input logic [ADDR_WIDTH-1:0] addr);
    // Untouched words read back their own address
    if (!mem.exists(addr[ADDR_WIDTH-1:2])) begin
      return {addr[ADDR_WIDTH-1:2], 2'b00};
    end
    return mem[addr[ADDR_WIDTH-1:2]];
  endfunction

  task automatic draw_delays();
    aw_wait = int'($urandom % 32'd4);
    w_wait  = int'($urandom % 32'd4);
    b_wait  = int'($urandom % 32'd4);
    ar_wait = int'($urandom % 32'd4);
    r_wait  = int'($urandom % 32'd4);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors++;
    $display("ERR %s expected %h got %h", name, expected, actual);
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
  endtask

  task automatic finish_test(input string name, input int start);
    tests++;
    $display("%s: %0d errors", name, errors - start);
  endtask

  // AXI4-Lite slave that decides on the falling edge what fires at the next rising edge
  always @(negedge clock) begin
    awready = 1'b0;
    wready  = 1'b0;
    arready = 1'b0;
    if (b_fire) begin
      bvalid = 1'b0;
      b_fire = 1'b0;
    end
    if (r_fire) begin
      rvalid = 1'b0;
      r_fire = 1'b0;
    end
    // Responses come at least a cycle after their requests
    if (aw_held && w_held && !bvalid) begin
      if (b_wait == 0) bvalid = 1'b1;
      else b_wait--;
    end
    if (ar_held && !rvalid) begin
      if (r_wait == 0) begin
        rvalid = 1'b1;
        rdata  = mem_read(rd_addr_q);
      end else begin
        r_wait--;
      end
    end
    if (awvalid && !aw_held) begin
      if (aw_wait == 0) begin
        awready   = 1'b1;
        aw_held   = 1'b1;
        wr_addr_q = awaddr;
      end else begin
        aw_wait--;
      end
    end
    if (wvalid && !w_held) begin
      if (w_wait == 0) begin
        wready    = 1'b1;
        w_held    = 1'b1;
        wr_data_q = wdata;
        if (wstrb !== {STRB_WIDTH{1'b1}}) report_mismatch("wstrb", 32'hf, 32'(wstrb));
      end else begin
        w_wait--;
      end
    end
    if (arvalid && !ar_held) begin
      if (ar_wait == 0) begin
        arready   = 1'b1;
        ar_held   = 1'b1;
        rd_addr_q = araddr;
      end else begin
        ar_wait--;
      end
    end
    if (bvalid && bready && !b_fire) begin
      b_fire = 1'b1;
      aw_held = 1'b0;
      w_held  = 1'b0;
      mem[wr_addr_q[ADDR_WIDTH-1:2]] = wr_data_q;
      write_log_addr.push_back(wr_addr_q);
      write_log_data.push_back(wr_data_q);
      draw_delays();
    end
    if (rvalid && rready && !r_fire) begin
      r_fire  = 1'b1;
      ar_held = 1'b0;
      draw_delays();
    end
  end

  // Tasks start and end on a falling edge
  task automatic dispatch_one(input logic is_store, input sq_ptr_t exp_idx);
    int waited;
    waited = 0;
    dispatch_valid = 1'b1;
    dispatch_store = is_store;
    #1;
    while (!dispatch_ready && waited < TIMEOUT_CYCLES) begin
      @(negedge clock);
      #1;
      waited++;
    end
    if (!dispatch_ready) begin
      report_timeout("dispatch_ready");
    end else if (dispatch_sq_idx !== exp_idx) begin
      report_mismatch("dispatch_sq_idx", 32'(exp_idx), 32'(dispatch_sq_idx));
    end
    @(negedge clock);
    dispatch_valid = 1'b0;
    dispatch_store = 1'b0;
  endtask

  task automatic exec_store(input int slot);
    exec_valid = 1'b1;
    exec_idx   = SQ_IDX_WIDTH'(slot);
    exec_addr  = store_addr[slot];
    exec_data  = store_data[slot];
    @(negedge clock);
    exec_valid = 1'b0;
  endtask

  task automatic load_and_check(input logic [ADDR_WIDTH-1:0] addr, input sq_ptr_t bound,
                                input logic [DATA_WIDTH-1:0] exp_data, input logic exp_fwd);
    int waited;
    waited = 0;
    load_valid  = 1'b1;
    load_addr   = addr;
    load_sq_idx = bound;
    while (!load_ready && waited < TIMEOUT_CYCLES) begin
      @(negedge clock);
      waited++;
    end
    if (!load_ready) begin
      report_timeout("load_ready");
      load_valid = 1'b0;
      return;
    end
    @(negedge clock);
    load_valid = 1'b0;
    // A hit answers in the next cycle and a miss starts the read instead
    if (load_resp_valid !== exp_fwd) begin
      report_mismatch("load_resp_valid", 32'(exp_fwd), 32'(load_resp_valid));
    end
    if (!exp_fwd && arvalid !== 1'b1) report_mismatch("arvalid", 32'd1, 32'(arvalid));
    waited = 0;
    while (!load_resp_valid && waited < TIMEOUT_CYCLES) begin
      @(negedge clock);
      waited++;
    end
    if (!load_resp_valid) begin
      report_timeout("load_resp_valid");
      return;
    end
    if (load_resp_data !== exp_data) begin
      report_mismatch("load_resp_data", exp_data, load_resp_data);
    end
    if (load_resp_forwarded !== exp_fwd) begin
      report_mismatch("load_resp_forwarded", 32'(exp_fwd), 32'(load_resp_forwarded));
    end
    load_resp_ready = 1'b1;
    @(negedge clock);
    load_resp_ready = 1'b0;
    if (load_resp_valid !== 1'b0) report_mismatch("load_resp_valid", 32'd0, 32'(load_resp_valid));
  endtask

  task automatic check_reset();
    int start;
    start = errors;
    dispatch_store = 1'b1;
    #1;
    if (dispatch_ready !== 1'b1) report_mismatch("dispatch_ready", 32'd1, 32'(dispatch_ready));
    if (load_ready !== 1'b1) report_mismatch("load_ready", 32'd1, 32'(load_ready));
    if (awvalid !== 1'b0) report_mismatch("awvalid", 32'd0, 32'(awvalid));
    if (wvalid !== 1'b0) report_mismatch("wvalid", 32'd0, 32'(wvalid));
    if (bready !== 1'b0) report_mismatch("bready", 32'd0, 32'(bready));
    if (arvalid !== 1'b0) report_mismatch("arvalid", 32'd0, 32'(arvalid));
    if (rready !== 1'b0) report_mismatch("rready", 32'd0, 32'(rready));
    if (load_resp_valid !== 1'b0) report_mismatch("load_resp_valid", 32'd0, 32'(load_resp_valid));
    @(negedge clock);
    dispatch_store = 1'b0;
    finish_test("reset", start);
  endtask

  task automatic alloc_until_full();
    int start;
    start = errors;
    for (int i = 0; i < SQ_DEPTH; i++) begin
      dispatch_one(1'b1, sq_ptr_t'(i));
    end
    // Ninth store stalls
    dispatch_valid = 1'b1;
    dispatch_store = 1'b1;
    #1;
    if (dispatch_ready !== 1'b0) report_mismatch("dispatch_ready", 32'd0, 32'(dispatch_ready));
    @(negedge clock);
    // A load still gets the wrapped tail as its boundary
    dispatch_store = 1'b0;
    #1;
    if (dispatch_ready !== 1'b1) report_mismatch("dispatch_ready", 32'd1, 32'(dispatch_ready));
    if (dispatch_sq_idx !== sq_ptr_t'(SQ_DEPTH)) begin
      report_mismatch("dispatch_sq_idx", 32'(SQ_DEPTH), 32'(dispatch_sq_idx));
    end
    load_bound = dispatch_sq_idx;
    @(negedge clock);
    dispatch_valid = 1'b0;
    finish_test("alloc_full", start);
  endtask

  task automatic forward_youngest();
    int start;
    start = errors;
    for (int i = 0; i < SQ_DEPTH; i++) begin
      exec_store(i);
    end
    load_and_check(32'h100, load_bound, store_data[2], 1'b1);
    // Slot 1 is younger but on another word
    load_and_check(32'h100, sq_ptr_t'(2), store_data[0], 1'b1);
    load_and_check(32'h204, load_bound, 32'h204, 1'b0);
    finish_test("forward", start);
  endtask

  task automatic age_boundary();
    int start;
    start = errors;
    load_and_check(32'h400, sq_ptr_t'(4), 32'h400, 1'b0);
    load_and_check(32'h400, sq_ptr_t'(5), store_data[4], 1'b1);
    finish_test("age_boundary", start);
  endtask

  task automatic drain_in_order();
    int start;
    int waited;
    start = errors;
    for (int i = 0; i < SQ_DEPTH; i++) begin
      commit_valid = 1'b1;
      @(negedge clock);
      commit_valid = 1'b0;
      #1;
      waited = 0;
      while (write_log_addr.size() <= i && waited < TIMEOUT_CYCLES) begin
        @(negedge clock);
        #1;
        waited++;
      end
      if (write_log_addr.size() <= i) report_timeout("the store write");
      @(negedge clock);
      // Freed slot no longer forwards and memory holds the new word
      load_and_check(store_addr[i], sq_ptr_t'(i + 1), store_data[i], 1'b0);
    end
    if (write_log_addr.size() != SQ_DEPTH) begin
      report_mismatch("write count", 32'(SQ_DEPTH), 32'(write_log_addr.size()));
    end
    for (int i = 0; i < SQ_DEPTH && i < write_log_addr.size(); i++) begin
      if (write_log_addr[i] !== (store_addr[i] & ~32'h3)) begin
        report_mismatch("awaddr", store_addr[i] & ~32'h3, write_log_addr[i]);
      end
      if (write_log_data[i] !== store_data[i]) begin
        report_mismatch("wdata", store_data[i], write_log_data[i]);
      end
    end
    dispatch_one(1'b1, sq_ptr_t'(SQ_DEPTH));
    dispatch_one(1'b1, sq_ptr_t'(SQ_DEPTH + 1));
    finish_test("drain", start);
  endtask

  initial begin
    void'($urandom(98402));
    draw_delays();
    errors          = 0;
    tests           = 0;
    reset           = 1'b1;
    dispatch_valid  = 1'b0;
    dispatch_store  = 1'b0;
    exec_valid      = 1'b0;
    exec_idx        = '0;
    exec_addr       = '0;
    exec_data       = '0;
    commit_valid    = 1'b0;
    load_valid      = 1'b0;
    load_addr       = '0;
    load_sq_idx     = '0;
    load_resp_ready = 1'b0;
    store_addr = '{32'h100, 32'h200, 32'h102, 32'h300, 32'h400, 32'h500, 32'h600, 32'h700};
    for (int i = 0; i < SQ_DEPTH; i++) begin
      store_data[i] = $urandom;
    end
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    check_reset();
    alloc_until_full();
    forward_youngest();
    age_boundary();
    drain_in_order();
    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
